//--- logic/cdr_const_pkg.sv
package cdr_const_pkg;

    // ADC sample width in bits.
    localparam int Nadc = 8;

    // interleaved lanes delivered on every clock.
    localparam int Nti = 4;

    // phase interpolator code width.
    localparam int Npi = 8;

    // number of phase interpolators driven by the loop.
    localparam int Nout = 2;

    // width of the phase error and of the integer part of every estimate.
    localparam int pe_width = Nadc + 2;

endpackage

//--- logic/cdr_ctrl_pkg.sv
package cdr_ctrl_pkg;

    // left-shift amount applied to the phase error.
    typedef logic [3:0] gain_t;

    // loop configuration as seen on the debug port.
    typedef struct packed {
        gain_t                                    kp;
        gain_t                                    ki;
        gain_t                                    kr;
        logic signed [cdr_const_pkg::pe_width-1:0] pd_offset;
        logic                                     en_ramp_est;
        logic                                     en_freq_est;
        logic                                     en_ext_pi_ctl;
        logic [cdr_const_pkg::Npi-1:0]             ext_pi_ctl;
        // level request for a snapshot of the loop state.
        logic                                     sample_state;
    } cdr_cfg_t;

    // integer parts of the loop state captured by the snapshot block.
    typedef struct packed {
        logic signed [cdr_const_pkg::pe_width-1:0] phase_est;
        logic signed [cdr_const_pkg::pe_width-1:0] freq_est;
        logic signed [cdr_const_pkg::pe_width-1:0] ramp_est;
    } cdr_status_t;

endpackage

//--- logic/mm_pd.sv
module mm_pd (
    input  logic signed [cdr_const_pkg::Nadc-1:0]     din_i [cdr_const_pkg::Nti],
    input  logic signed [cdr_const_pkg::pe_width-1:0] pd_offset_i,
    output logic signed [cdr_const_pkg::pe_width-1:0] pd_out_o
);
    import cdr_const_pkg::*;

    // wide enough for the sum of all lane terms plus the offset.
    localparam int sum_w  = Nadc + 4;
    localparam int pe_max = 2 ** (pe_width - 1) - 1;
    localparam int pe_min = -(2 ** (pe_width - 1));

    logic signed [sum_w-1:0] acc;
    logic signed [sum_w-1:0] cur;
    logic signed [sum_w-1:0] prev;
    logic signed [sum_w-1:0] err_sum;

    always_comb begin
        acc = '0;
        cur = '0;
        prev = '0;
        for (int k = 1; k < Nti; k++) begin
            cur  = din_i[k];
            prev = din_i[k-1];
            // sign() is +1 for zero, so only the MSB decides.
            acc = acc + (prev[sum_w-1] ? -cur : cur) - (cur[sum_w-1] ? -prev : prev);
        end
        err_sum = (acc >>> 1) + pd_offset_i;
    end

    // clamp to the phase error range instead of wrapping.
    always_comb begin
        if (err_sum > pe_max) begin
            pd_out_o = pe_width'(pe_max);
        end else if (err_sum < pe_min) begin
            pd_out_o = pe_width'(pe_min);
        end else begin
            pd_out_o = err_sum[pe_width-1:0];
        end
    end

endmodule

//--- logic/mm_cdr.sv
module mm_cdr #(
    parameter int phase_est_shift = 16
) (
    input  logic                                      clk,
    input  logic                                      ext_rstb,
    input  logic signed [cdr_const_pkg::Nadc-1:0]     din_i [cdr_const_pkg::Nti],
    input  logic                                      ramp_clock_i,
    input  cdr_ctrl_pkg::cdr_cfg_t                    cfg_i,
    output logic [cdr_const_pkg::Npi-1:0]             pi_ctl_o [cdr_const_pkg::Nout],
    output logic                                      freq_lvl_cross_o,
    output logic signed [cdr_const_pkg::pe_width-1:0] phase_int_o,
    output logic signed [cdr_const_pkg::pe_width+phase_est_shift:0] freq_update_o,
    output logic signed [cdr_const_pkg::pe_width+phase_est_shift:0] ramp_update_o
);
    import cdr_const_pkg::*;

    localparam int est_w = pe_width + phase_est_shift + 1;
    localparam logic signed [est_w:0] one_unit = (est_w + 1)'(1) << phase_est_shift;

    logic [4:0]                 warm_cnt;
    logic                       loop_en;
    logic signed [pe_width-1:0] pd_err;
    logic signed [pe_width-1:0] phase_err_q;
    logic                       ramp_ff;
    logic                       ramp_sync;
    logic signed [est_w-1:0]    err_kp;
    logic signed [est_w-1:0]    err_ki;
    logic signed [est_w-1:0]    err_kr;
    logic signed [est_w-1:0]    ramp_pls_q;
    logic signed [est_w-1:0]    ramp_neg_q;
    logic signed [est_w-1:0]    ramp_pls_upd;
    logic signed [est_w-1:0]    ramp_neg_upd;
    logic signed [est_w-1:0]    freq_q;
    logic signed [est_w-1:0]    freq_upd;
    logic signed [est_w-1:0]    prev_freq_upd_q;
    logic signed [est_w:0]      freq_diff;
    logic signed [est_w-1:0]    phase_q;
    logic signed [est_w-1:0]    phase_upd;
    logic signed [est_w:0]      phase_sum;
    logic signed [est_w:0]      up_bnd;
    logic signed [est_w:0]      lo_bnd;
    logic signed [est_w:0]      phase_nxt;

    mm_pd mm_pd_inst (
        .din_i       (din_i),
        .pd_offset_i (cfg_i.pd_offset),
        .pd_out_o    (pd_err)
    );

    assign err_kp = phase_err_q;
    assign err_ki = phase_err_q;
    assign err_kr = phase_err_q;

    always_comb begin
        ramp_pls_upd = ramp_pls_q;
        ramp_neg_upd = ramp_neg_q;
        // the raw ramp level steers which accumulator integrates.
        if (ramp_clock_i) begin
            ramp_pls_upd = ramp_pls_q + (err_kr <<< cfg_i.kr);
        end else begin
            ramp_neg_upd = ramp_neg_q + (err_kr <<< cfg_i.kr);
        end

        if (ramp_sync) begin
            freq_upd = (err_ki <<< cfg_i.ki) + ramp_pls_q;
        end else begin
            freq_upd = (err_ki <<< cfg_i.ki) - ramp_neg_q;
        end
        freq_diff = freq_upd - prev_freq_upd_q;

        phase_upd = (err_kp <<< cfg_i.kp) + freq_q;
        phase_sum = phase_q + phase_upd;

        // integer boundaries just above and below the current phase.
        up_bnd = phase_q + one_unit;
        up_bnd[phase_est_shift-1:0] = '0;
        lo_bnd = phase_q - one_unit;
        lo_bnd[phase_est_shift-1:0] = '0;

        if (phase_sum > up_bnd) begin
            phase_nxt = phase_q + one_unit;
        end else if (phase_sum < lo_bnd) begin
            phase_nxt = phase_q - one_unit;
        end else begin
            phase_nxt = phase_sum;
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            warm_cnt        <= '0;
            loop_en         <= 1'b0;
            ramp_ff         <= 1'b0;
            ramp_sync       <= 1'b0;
            freq_lvl_cross_o <= 1'b0;
            phase_err_q     <= '0;
            ramp_pls_q      <= '0;
            ramp_neg_q      <= '0;
            freq_q          <= '0;
            prev_freq_upd_q <= '0;
            phase_q         <= '0;
        end else begin
            // hold the loop quiet for 32 cycles after every reset.
            warm_cnt  <= (warm_cnt == 5'd31) ? warm_cnt : warm_cnt + 5'd1;
            loop_en   <= (warm_cnt == 5'd31);
            ramp_ff   <= ramp_clock_i;
            ramp_sync <= ramp_ff;
            freq_lvl_cross_o <= (freq_diff > 0);
            if (loop_en) begin
                phase_err_q     <= pd_err;
                ramp_pls_q      <= cfg_i.en_ramp_est ? ramp_pls_upd : '0;
                ramp_neg_q      <= cfg_i.en_ramp_est ? ramp_neg_upd : '0;
                freq_q          <= cfg_i.en_freq_est ? freq_q + freq_upd : freq_q;
                prev_freq_upd_q <= freq_upd;
                phase_q         <= phase_nxt[est_w-1:0];
            end else begin
                phase_err_q     <= '0;
                ramp_pls_q      <= '0;
                ramp_neg_q      <= '0;
                freq_q          <= '0;
                prev_freq_upd_q <= '0;
                phase_q         <= '0;
            end
        end
    end

    assign phase_int_o   = phase_q[phase_est_shift +: pe_width];
    assign freq_update_o = freq_upd;
    assign ramp_update_o = ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;

    for (genvar i = 0; i < Nout; i++) begin : g_pi
        assign pi_ctl_o[i] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : phase_int_o[Npi-1:0];
    end

endmodule

//--- logic/cdr_snapshot.sv
module cdr_snapshot #(
    parameter int phase_est_shift = 16
) (
    input  logic                                      clk,
    input  logic                                      ext_rstb,
    input  logic                                      sample_state_i,
    input  logic signed [cdr_const_pkg::pe_width-1:0] phase_int_i,
    input  logic signed [cdr_const_pkg::pe_width+phase_est_shift:0] freq_update_i,
    input  logic signed [cdr_const_pkg::pe_width+phase_est_shift:0] ramp_update_i,
    output cdr_ctrl_pkg::cdr_status_t                 status_o
);
    import cdr_const_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_READY,
        ST_SAMPLE
    } snap_state_t;

    snap_state_t state;

    // arm on a low request, fire once on the next high level.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state    <= ST_WAIT;
            status_o <= '0;
        end else begin
            case (state)
                ST_WAIT: begin
                    state <= sample_state_i ? ST_WAIT : ST_READY;
                end
                ST_READY: begin
                    state <= sample_state_i ? ST_SAMPLE : ST_READY;
                end
                ST_SAMPLE: begin
                    status_o.phase_est <= phase_int_i;
                    // keep only the integer part of the wide updates.
                    status_o.freq_est  <= freq_update_i[phase_est_shift +: pe_width];
                    status_o.ramp_est  <= ramp_update_i[phase_est_shift +: pe_width];
                    state              <= ST_WAIT;
                end
                default: begin
                    state <= ST_WAIT;
                end
            endcase
        end
    end

endmodule

//--- logic/cdr_top.sv
module cdr_top #(
    parameter int phase_est_shift = 16
) (
    input  logic                                  clk,
    input  logic                                  ext_rstb,
    input  logic signed [cdr_const_pkg::Nadc-1:0] din_i [cdr_const_pkg::Nti],
    input  logic                                  ramp_clock_i,
    input  cdr_ctrl_pkg::cdr_cfg_t                cfg_i,
    output logic [cdr_const_pkg::Npi-1:0]         pi_ctl_o [cdr_const_pkg::Nout],
    output logic                                  freq_lvl_cross_o,
    output cdr_ctrl_pkg::cdr_status_t             status_o
);
    import cdr_const_pkg::*;

    localparam int est_w = pe_width + phase_est_shift + 1;

    logic signed [pe_width-1:0] phase_int;
    logic signed [est_w-1:0]    freq_update;
    logic signed [est_w-1:0]    ramp_update;

    mm_cdr #(
        .phase_est_shift (phase_est_shift)
    ) mm_cdr_inst (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din_i),
        .ramp_clock_i     (ramp_clock_i),
        .cfg_i            (cfg_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_int_o      (phase_int),
        .freq_update_o    (freq_update),
        .ramp_update_o    (ramp_update)
    );

    cdr_snapshot #(
        .phase_est_shift (phase_est_shift)
    ) cdr_snapshot_inst (
        .clk            (clk),
        .ext_rstb       (ext_rstb),
        .sample_state_i (cfg_i.sample_state),
        .phase_int_i    (phase_int),
        .freq_update_i  (freq_update),
        .ramp_update_i  (ramp_update),
        .status_o       (status_o)
    );

endmodule

//--- bench/cdr_top_tb.sv
module cdr_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cdr_const_pkg::*;
    import cdr_ctrl_pkg::*;

    localparam int frac_w = 16;
    localparam int est_w = pe_width + frac_w + 1;
    localparam longint unit = longint'(1) << frac_w;
    localparam logic [1:0] snap_wait = 2'd0;
    localparam logic [1:0] snap_ready = 2'd1;
    localparam logic [1:0] snap_fire = 2'd2;
    localparam int test_cycles = 3 + 40 + 30 + 3 * 40 + 150 + 8 * 15 + 34 + 2;
    localparam int timeout_ns = (test_cycles + 200) * 10;

    // the reference loop keeps one field for every DUT register.
    typedef struct packed {
        logic [4:0]                warm_cnt;
        logic                      loop_en;
        logic                      ramp_ff;
        logic                      ramp_sync;
        logic                      lvl_cross;
        logic [pe_width-1:0]       perr;
        logic [est_w-1:0]          ramp_pls;
        logic [est_w-1:0]          ramp_neg;
        logic [est_w-1:0]          freq;
        logic [est_w-1:0]          prev_fu;
        logic [est_w-1:0]          phase;
        logic [1:0]                snap;
        cdr_status_t               status;
    } loop_model_t;

    logic                       clk = 1'b0;
    logic                       ext_rstb;
    logic signed [Nadc-1:0]     din [Nti];
    logic                       ramp_clock;
    cdr_cfg_t                   cfg;
    logic [Npi-1:0]             pi_ctl [Nout];
    logic                       freq_lvl_cross;
    cdr_status_t                status;

    loop_model_t    model;
    logic [31:0]    lfsr = 32'hf5e7_4c14;
    int             value_errs = 0;
    int             other_errs = 0;
    int             captures = 0;
    int             requests = 0;
    int             warm_seen = 0;
    logic [Npi-1:0] prev_pi = '0;
    logic           prev_valid = 1'b0;

    cdr_top #(
        .phase_est_shift (frac_w)
    ) cdr_top_inst (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .ramp_clock_i     (ramp_clock),
        .cfg_i            (cfg),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .status_o         (status)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic longint to_signed(input longint raw, input int w);
        if (raw[w-1]) begin
            return raw - (longint'(1) << w);
        end
        return raw;
    endfunction

    // two's complement wrap to the estimate width.
    function automatic longint norm(input longint v);
        return to_signed(v & ((longint'(1) << est_w) - 1), est_w);
    endfunction

    function automatic int sign_of(input int x);
        return (x < 0) ? -1 : 1;
    endfunction

    function automatic logic [pe_width-1:0] pd_ref(input logic signed [Nadc-1:0] lanes [Nti],
                                                   input logic [pe_width-1:0] offset);
        int cur;
        int prev;
        int sum;
        sum = 0;
        for (int k = 1; k < Nti; k++) begin
            cur = lanes[k];
            prev = lanes[k-1];
            sum = sum + cur * sign_of(prev) - prev * sign_of(cur);
        end
        sum = (sum >>> 1) + int'(to_signed(offset, pe_width));
        if (sum > 2 ** (pe_width - 1) - 1) begin
            sum = 2 ** (pe_width - 1) - 1;
        end else if (sum < -(2 ** (pe_width - 1))) begin
            sum = -(2 ** (pe_width - 1));
        end
        return pe_width'(sum);
    endfunction

    function automatic loop_model_t loop_step(input loop_model_t s,
                                              input logic signed [Nadc-1:0] lanes [Nti],
                                              input logic ramp,
                                              input cdr_cfg_t c);
        loop_model_t n;
        longint perr;
        longint pls;
        longint neg;
        longint freq;
        longint prev;
        longint ph;
        longint pls_upd;
        longint neg_upd;
        longint f_upd;
        longint ph_upd;
        longint ph_sum;
        longint base;
        longint ph_nxt;
        longint r_upd;
        n = s;
        perr = to_signed(s.perr, pe_width);
        pls = to_signed(s.ramp_pls, est_w);
        neg = to_signed(s.ramp_neg, est_w);
        freq = to_signed(s.freq, est_w);
        prev = to_signed(s.prev_fu, est_w);
        ph = to_signed(s.phase, est_w);

        pls_upd = ramp ? norm(pls + perr * (longint'(1) << c.kr)) : pls;
        neg_upd = ramp ? neg : norm(neg + perr * (longint'(1) << c.kr));
        f_upd = norm(perr * (longint'(1) << c.ki) + (s.ramp_sync ? pls : -neg));
        ph_upd = norm(perr * (longint'(1) << c.kp) + freq);
        ph_sum = ph + ph_upd;
        // the phase may cross at most one integer boundary per clock.
        base = (ph >>> frac_w) <<< frac_w;
        if (ph_sum > base + unit) begin
            ph_nxt = ph + unit;
        end else if (ph_sum < base - unit) begin
            ph_nxt = ph - unit;
        end else begin
            ph_nxt = ph_sum;
        end
        r_upd = ramp ? pls_upd : neg_upd;

        n.lvl_cross = (f_upd - prev) > 0;
        n.warm_cnt = (s.warm_cnt == 5'd31) ? s.warm_cnt : s.warm_cnt + 5'd1;
        n.loop_en = (s.warm_cnt == 5'd31);
        n.ramp_ff = ramp;
        n.ramp_sync = s.ramp_ff;
        n.perr = s.loop_en ? pd_ref(lanes, c.pd_offset) : '0;
        n.ramp_pls = (s.loop_en && c.en_ramp_est) ? est_w'(pls_upd) : '0;
        n.ramp_neg = (s.loop_en && c.en_ramp_est) ? est_w'(neg_upd) : '0;
        n.freq = !s.loop_en ? '0 : (c.en_freq_est ? est_w'(norm(freq + f_upd)) : s.freq);
        n.prev_fu = s.loop_en ? est_w'(f_upd) : '0;
        n.phase = s.loop_en ? est_w'(norm(ph_nxt)) : '0;

        case (s.snap)
            snap_wait: n.snap = c.sample_state ? snap_wait : snap_ready;
            snap_ready: n.snap = c.sample_state ? snap_fire : snap_ready;
            default: begin
                n.status.phase_est = pe_width'(ph >>> frac_w);
                n.status.freq_est = pe_width'(f_upd >>> frac_w);
                n.status.ramp_est = pe_width'(r_upd >>> frac_w);
                n.snap = snap_wait;
            end
        endcase
        return n;
    endfunction

    function automatic logic [Npi-1:0] expected_pi(input loop_model_t s,
                                                   input cdr_cfg_t c);
        return c.en_ext_pi_ctl ? c.ext_pi_ctl : s.phase[frac_w +: Npi];
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
        value_errs++;
    endtask

    task automatic run_cycles(input int n, input bit toggle_ramp, input bit rand_ext);
        repeat (n) begin
            @(posedge clk);
            for (int k = 0; k < Nti; k++) begin
                din[k] <= Nadc'(rand_bits(Nadc));
            end
            if (toggle_ramp && rand_bits(2) == 32'd0) begin
                ramp_clock <= ~ramp_clock;
            end
            if (rand_ext) begin
                cfg.ext_pi_ctl <= Npi'(rand_bits(Npi));
            end
        end
    endtask

    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            model = '0;
        end else begin
            if (model.snap == snap_fire) begin
                captures++;
            end
            model = loop_step(model, din, ramp_clock, cfg);
        end
    end

    // compare the DUT against the model at every falling edge.
    always @(negedge clk) begin
        logic [Npi-1:0] exp_pi;
        logic [Npi-1:0] step;
        exp_pi = expected_pi(model, cfg);
        for (int i = 0; i < Nout; i++) begin
            if (pi_ctl[i] !== exp_pi) begin
                report_value($sformatf("pi_ctl_o[%0d]", i), 32'(exp_pi), 32'(pi_ctl[i]));
            end
        end
        if (freq_lvl_cross !== model.lvl_cross) begin
            report_value("freq_lvl_cross_o", 32'(model.lvl_cross), 32'(freq_lvl_cross));
        end
        if (status !== model.status) begin
            report_value("status_o", 32'(model.status), 32'(status));
        end
        if (ext_rstb) begin
            warm_seen++;
        end
        if (ext_rstb && warm_seen <= 32) begin
            if (pi_ctl[0] != '0 || freq_lvl_cross || status != '0) begin
                $display("loop output became active during warm-up at %0t", $time);
                other_errs++;
            end
        end
        if (!cfg.en_ext_pi_ctl && prev_valid) begin
            step = pi_ctl[0] - prev_pi;
            if (step != 8'd0 && step != 8'd1 && step != 8'hff) begin
                $display("interpolator code jumped by more than one step at %0t", $time);
                other_errs++;
            end
        end
        prev_valid = !cfg.en_ext_pi_ctl;
        prev_pi = pi_ctl[0];
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the test sequence did not finish", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [5:0] off6;
        ext_rstb = 1'b0;
        ramp_clock = 1'b0;
        cfg = '0;
        cfg.kp = 4'd4;
        for (int k = 0; k < Nti; k++) begin
            din[k] = '0;
        end
        repeat (3) @(posedge clk);
        ext_rstb <= 1'b1;

        // the loop stays quiet through warm-up and then the first-order loop starts to move.
        run_cycles(40, 0, 0);

        cfg.en_ext_pi_ctl <= 1'b1;
        run_cycles(20, 0, 1);
        cfg.en_ext_pi_ctl <= 1'b0;
        run_cycles(10, 0, 0);

        for (int i = 0; i < 3; i++) begin
            off6 = 6'(rand_bits(6));
            cfg.kp <= 4'(2 + 4 * i);
            cfg.pd_offset <= {{(pe_width - 6){off6[5]}}, off6};
            run_cycles(40, 0, 0);
        end

        cfg.kp <= 4'd5;
        cfg.ki <= 4'd3;
        cfg.kr <= 4'd1;
        cfg.en_freq_est <= 1'b1;
        cfg.en_ramp_est <= 1'b1;
        run_cycles(150, 1, 0);

        for (int r = 0; r < 8; r++) begin
            cfg.sample_state <= 1'b0;
            run_cycles(3 + int'(rand_bits(3)), 1, 0);
            cfg.sample_state <= 1'b1;
            run_cycles(2 + int'(rand_bits(2)), 1, 0);
            requests++;
        end

        // a long request level must still fire only once.
        cfg.sample_state <= 1'b0;
        run_cycles(4, 1, 0);
        cfg.sample_state <= 1'b1;
        run_cycles(25, 1, 0);
        requests++;
        cfg.sample_state <= 1'b0;
        run_cycles(5, 1, 0);
        run_cycles(2, 0, 0);

        if (captures != requests) begin
            $display("snapshot fired %0d times for %0d requests", captures, requests);
            other_errs++;
        end
        $display("test done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- cdr_top.f
logic/cdr_const_pkg.sv
logic/cdr_ctrl_pkg.sv
logic/mm_pd.sv
logic/mm_cdr.sv
logic/cdr_snapshot.sv
logic/cdr_top.sv
bench/cdr_top_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --top-module cdr_top_tb -f cdr_top.f -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/Vcdr_top_tb" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^>>> FAIL$' "$log"; then
    exit 1
fi
exit 0
